// File: verilog/id_pkg.sv
/* Decode stage definitions */

package id_pkg;

  // ====================
  // Widths
  // ====================
  localparam int XLEN       = 64;   // Data and address width
  localparam int ILEN       = 32;   // Instruction width
  localparam int REG_ADDR_W = 5;    // Register index width
  localparam int OPC_W      = 7;    // Major opcode width

  // ====================
  // Major opcodes
  // ====================
  typedef enum logic [OPC_W-1:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // ====================
  // Instruction formats
  // ====================
  // IT_NONE marks an opcode outside the supported set
  typedef enum logic [2:0] {
    IT_NONE = 3'd0,
    IT_R    = 3'd1,
    IT_I    = 3'd2,
    IT_S    = 3'd3,
    IT_B    = 3'd4,
    IT_U    = 3'd5,
    IT_J    = 3'd6
  } itype_e;

endpackage

// File: verilog/id_ifaces.sv
/* Decode stage interfaces */

// Holding register of the stage towards the decoder
interface fetch_if;
  logic                    valid;     // Stage holds an instruction
  logic [id_pkg::ILEN-1:0] inst;
  logic [id_pkg::XLEN-1:0] pc;
  logic [id_pkg::XLEN-1:0] pc_pred;

  modport stage (output valid, output inst, output pc, output pc_pred);
  modport dec   (input valid, input inst, input pc, input pc_pred);
endinterface

// Decoded bundle towards the output register
interface dec_if;
  logic                          valid;
  logic                          pop;    // Output register takes the bundle
  logic [id_pkg::REG_ADDR_W-1:0] rd;
  logic                          rd_wen;
  id_pkg::itype_e                itype;
  logic [id_pkg::OPC_W-1:0]      opcode;
  logic [2:0]                    funct3;
  logic [6:0]                    funct7;
  logic [id_pkg::XLEN-1:0]       op1;
  logic [id_pkg::XLEN-1:0]       op2;
  logic [id_pkg::XLEN-1:0]       t1;
  logic                          memren;
  logic                          memwen;
  logic [id_pkg::XLEN-1:0]       memaddr;
  logic [id_pkg::XLEN-1:0]       memwdata;
  logic [id_pkg::XLEN-1:0]       pc;
  logic [id_pkg::XLEN-1:0]       pc_pred;
  logic                          illegal;

  modport dec (
    output valid, output rd, output rd_wen, output itype, output opcode,
    output funct3, output funct7, output op1, output op2, output t1,
    output memren, output memwen, output memaddr, output memwdata,
    output pc, output pc_pred, output illegal
  );
  modport ex (
    input valid, output pop, input rd, input rd_wen, input itype, input opcode,
    input funct3, input funct7, input op1, input op2, input t1,
    input memren, input memwen, input memaddr, input memwdata,
    input pc, input pc_pred, input illegal
  );
endinterface

// File: verilog/id_stage.sv
/* Decode input stage */

module id_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_fetch_req,
  output logic                    o_fetch_ack,
  input  logic [id_pkg::ILEN-1:0] i_inst,
  input  logic [id_pkg::XLEN-1:0] i_pc,
  input  logic [id_pkg::XLEN-1:0] i_pc_pred,
  fetch_if.stage                  fch,
  input  logic                    i_pop
);

  logic                    valid_q;
  logic [id_pkg::ILEN-1:0] inst_q;
  logic [id_pkg::XLEN-1:0] pc_q;
  logic [id_pkg::XLEN-1:0] pc_pred_q;
  logic                    fetch_hs;

  // Ready while empty or while the held instruction leaves this cycle
  assign o_fetch_ack = !valid_q || i_pop;
  assign fetch_hs    = i_fetch_req && o_fetch_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (fetch_hs) begin
      valid_q <= 1'b1;
    end else if (i_pop) begin
      valid_q <= 1'b0;
    end
  end

  // ====================
  // Fetched bundle
  // ====================
  always_ff @(posedge clk) begin
    if (fetch_hs) begin
      inst_q    <= i_inst;
      pc_q      <= i_pc;
      pc_pred_q <= i_pc_pred;
    end
  end

  assign fch.valid   = valid_q;
  assign fch.inst    = inst_q;
  assign fch.pc      = pc_q;
  assign fch.pc_pred = pc_pred_q;

endmodule

// File: verilog/regfile.sv
/* Integer register file */

module regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [id_pkg::REG_ADDR_W-1:0] i_rs1,
  input  logic [id_pkg::REG_ADDR_W-1:0] i_rs2,
  output logic [id_pkg::XLEN-1:0]       o_rs1_data,
  output logic [id_pkg::XLEN-1:0]       o_rs2_data,
  input  logic                          i_wb_en,
  input  logic [id_pkg::REG_ADDR_W-1:0] i_wb_rd,
  input  logic [id_pkg::XLEN-1:0]       i_wb_data
);

  localparam int NREGS = 1 << id_pkg::REG_ADDR_W;

  logic [id_pkg::XLEN-1:0] regs [NREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb_en && (i_wb_rd != '0)) begin  // x0 stays zero
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  // Combinational reads, a write shows after its edge
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: verilog/id_decoder.sv
/* RV64I instruction decoder */

module id_decoder (
  fetch_if.dec                          fch,
  dec_if.dec                            dec,
  output logic [id_pkg::REG_ADDR_W-1:0] o_rs1,
  output logic [id_pkg::REG_ADDR_W-1:0] o_rs2,
  input  logic [id_pkg::XLEN-1:0]       i_rs1_data,
  input  logic [id_pkg::XLEN-1:0]       i_rs2_data
);

  localparam logic [id_pkg::XLEN-1:0] LINK_OFS = 4;  // Return address step

  id_pkg::opcode_e               opc;
  id_pkg::itype_e                itype;
  logic [id_pkg::REG_ADDR_W-1:0] rd;
  logic [id_pkg::REG_ADDR_W-1:0] rs1;
  logic [id_pkg::REG_ADDR_W-1:0] rs2;
  logic [2:0]                    funct3;
  logic [6:0]                    funct7;
  logic                          rs1_ren;
  logic                          rs2_ren;
  logic                          rd_used;
  logic                          f3_used;
  logic                          f7_used;
  logic                          known;
  logic [id_pkg::XLEN-1:0]       imm;
  logic [id_pkg::XLEN-1:0]       base;
  logic [id_pkg::XLEN-1:0]       sum;

  // ====================
  // Fields
  // ====================
  assign opc    = id_pkg::opcode_e'(fch.inst[6:0]);
  assign rd     = fch.inst[11:7];
  assign funct3 = fch.inst[14:12];
  assign rs1    = fch.inst[19:15];
  assign rs2    = fch.inst[24:20];
  assign funct7 = fch.inst[31:25];

  // Format and live fields in the order rs1 rs2 rd f3 f7
  always_comb begin
    itype = id_pkg::IT_NONE;
    known = 1'b1;
    {rs1_ren, rs2_ren, rd_used, f3_used, f7_used} = 5'b00000;
    case (opc)
      id_pkg::OPC_OP: begin
        itype = id_pkg::IT_R;
        {rs1_ren, rs2_ren, rd_used, f3_used, f7_used} = 5'b11111;
      end
      id_pkg::OPC_OP_IMM: begin
        itype = id_pkg::IT_I;
        {rs1_ren, rs2_ren, rd_used, f3_used, f7_used} = 5'b10111;  // f7 picks SRAI
      end
      id_pkg::OPC_LOAD: begin
        itype = id_pkg::IT_I;
        {rs1_ren, rs2_ren, rd_used, f3_used, f7_used} = 5'b10110;
      end
      id_pkg::OPC_STORE: begin
        itype = id_pkg::IT_S;
        {rs1_ren, rs2_ren, rd_used, f3_used, f7_used} = 5'b11010;
      end
      id_pkg::OPC_BRANCH: begin
        itype = id_pkg::IT_B;
        {rs1_ren, rs2_ren, rd_used, f3_used, f7_used} = 5'b11010;
      end
      id_pkg::OPC_LUI, id_pkg::OPC_AUIPC: begin
        itype = id_pkg::IT_U;
        {rs1_ren, rs2_ren, rd_used, f3_used, f7_used} = 5'b00100;
      end
      id_pkg::OPC_JAL: begin
        itype = id_pkg::IT_J;
        {rs1_ren, rs2_ren, rd_used, f3_used, f7_used} = 5'b00100;
      end
      id_pkg::OPC_JALR: begin
        itype = id_pkg::IT_I;
        {rs1_ren, rs2_ren, rd_used, f3_used, f7_used} = 5'b10110;
      end
      default: known = 1'b0;
    endcase
  end

  // ====================
  // Immediate
  // ====================
  always_comb begin
    case (itype)
      id_pkg::IT_I: imm = {{(id_pkg::XLEN-12){fch.inst[31]}}, fch.inst[31:20]};
      id_pkg::IT_S: imm = {{(id_pkg::XLEN-12){fch.inst[31]}}, fch.inst[31:25], fch.inst[11:7]};
      id_pkg::IT_B: imm = {{(id_pkg::XLEN-13){fch.inst[31]}}, fch.inst[31], fch.inst[7],
                           fch.inst[30:25], fch.inst[11:8], 1'b0};
      id_pkg::IT_U: imm = {{(id_pkg::XLEN-32){fch.inst[31]}}, fch.inst[31:12], 12'b0};
      id_pkg::IT_J: imm = {{(id_pkg::XLEN-21){fch.inst[31]}}, fch.inst[31], fch.inst[19:12],
                           fch.inst[20], fch.inst[30:21], 1'b0};
      default:      imm = '0;
    endcase
  end

  // One adder serves memory address and all targets
  assign base = (opc == id_pkg::OPC_BRANCH || opc == id_pkg::OPC_JAL) ? fch.pc : i_rs1_data;
  assign sum  = base + imm;

  // Unused read ports look at x0
  assign o_rs1 = rs1_ren ? rs1 : '0;
  assign o_rs2 = rs2_ren ? rs2 : '0;

  // ====================
  // Operands and targets
  // ====================
  always_comb begin
    dec.op1      = '0;
    dec.op2      = '0;
    dec.t1       = '0;
    dec.memren   = 1'b0;
    dec.memwen   = 1'b0;
    dec.memaddr  = '0;
    dec.memwdata = '0;
    case (opc)
      id_pkg::OPC_OP: begin
        dec.op1 = i_rs1_data;
        dec.op2 = i_rs2_data;
      end
      id_pkg::OPC_OP_IMM: begin
        dec.op1 = i_rs1_data;
        dec.op2 = imm;
      end
      id_pkg::OPC_LOAD: begin
        dec.op1     = i_rs1_data;
        dec.op2     = imm;
        dec.memaddr = sum;
        dec.memren  = 1'b1;
      end
      id_pkg::OPC_STORE: begin
        dec.op1      = i_rs1_data;
        dec.op2      = imm;
        dec.memaddr  = sum;
        dec.memwdata = i_rs2_data;
        dec.memwen   = 1'b1;
      end
      id_pkg::OPC_BRANCH: begin
        dec.op1 = i_rs1_data;
        dec.op2 = i_rs2_data;
        dec.t1  = sum;
      end
      id_pkg::OPC_LUI: dec.op2 = imm;
      id_pkg::OPC_AUIPC: begin
        dec.op1 = fch.pc;
        dec.op2 = imm;
      end
      id_pkg::OPC_JAL: begin
        dec.op1 = fch.pc;
        dec.op2 = LINK_OFS;
        dec.t1  = sum;
      end
      id_pkg::OPC_JALR: begin
        dec.op1 = fch.pc;
        dec.op2 = LINK_OFS;
        dec.t1  = {sum[id_pkg::XLEN-1:1], 1'b0};  // Target is halfword aligned
      end
      default: ;
    endcase
  end

  assign dec.valid   = fch.valid;
  assign dec.rd      = rd_used ? rd : '0;
  assign dec.rd_wen  = rd_used && (rd != '0);
  assign dec.itype   = itype;
  assign dec.opcode  = fch.inst[6:0];
  assign dec.funct3  = f3_used ? funct3 : '0;
  assign dec.funct7  = f7_used ? funct7 : '0;
  assign dec.pc      = fch.pc;
  assign dec.pc_pred = fch.pc_pred;
  assign dec.illegal = !known;

endmodule

// File: verilog/id_ex_reg.sv
/* Decode to execute register */

module id_ex_reg (
  input  logic                          clk,
  input  logic                          rst,
  dec_if.ex                             dec,
  output logic                          o_ex_req,
  input  logic                          i_ex_ack,
  output logic [id_pkg::REG_ADDR_W-1:0] o_ex_rd,
  output logic                          o_ex_rd_wen,
  output id_pkg::itype_e                o_ex_itype,
  output logic [id_pkg::OPC_W-1:0]      o_ex_opcode,
  output logic [2:0]                    o_ex_funct3,
  output logic [6:0]                    o_ex_funct7,
  output logic [id_pkg::XLEN-1:0]       o_ex_op1,
  output logic [id_pkg::XLEN-1:0]       o_ex_op2,
  output logic [id_pkg::XLEN-1:0]       o_ex_t1,
  output logic                          o_ex_memren,
  output logic                          o_ex_memwen,
  output logic [id_pkg::XLEN-1:0]       o_ex_memaddr,
  output logic [id_pkg::XLEN-1:0]       o_ex_memwdata,
  output logic [id_pkg::XLEN-1:0]       o_ex_pc,
  output logic [id_pkg::XLEN-1:0]       o_ex_pc_pred,
  output logic                          o_ex_illegal
);

  logic req_q;
  logic load;

  // Take a new bundle when empty or when the held one is accepted now
  assign load    = dec.valid && (!req_q || i_ex_ack);
  assign dec.pop = load;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_q <= 1'b0;
    end else if (load) begin
      req_q <= 1'b1;
    end else if (i_ex_ack) begin
      req_q <= 1'b0;
    end
  end

  assign o_ex_req = req_q;

  // ====================
  // Held bundle
  // ====================
  always_ff @(posedge clk) begin
    if (load) begin
      o_ex_rd       <= dec.rd;
      o_ex_rd_wen   <= dec.rd_wen;
      o_ex_itype    <= dec.itype;
      o_ex_opcode   <= dec.opcode;
      o_ex_funct3   <= dec.funct3;
      o_ex_funct7   <= dec.funct7;
      o_ex_op1      <= dec.op1;
      o_ex_op2      <= dec.op2;
      o_ex_t1       <= dec.t1;
      o_ex_memren   <= dec.memren;
      o_ex_memwen   <= dec.memwen;
      o_ex_memaddr  <= dec.memaddr;
      o_ex_memwdata <= dec.memwdata;
      o_ex_pc       <= dec.pc;
      o_ex_pc_pred  <= dec.pc_pred;
      o_ex_illegal  <= dec.illegal;
    end
  end

endmodule

// File: verilog/id_subsys.sv
/* Instruction decode subsystem */

module id_subsys (
  input  logic                          clk,
  input  logic                          rst,
  // Fetch side
  input  logic                          i_fetch_req,
  output logic                          o_fetch_ack,
  input  logic [id_pkg::ILEN-1:0]       i_inst,
  input  logic [id_pkg::XLEN-1:0]       i_pc,
  input  logic [id_pkg::XLEN-1:0]       i_pc_pred,
  // Register writeback
  input  logic                          i_wb_en,
  input  logic [id_pkg::REG_ADDR_W-1:0] i_wb_rd,
  input  logic [id_pkg::XLEN-1:0]       i_wb_data,
  // Execute side
  output logic                          o_ex_req,
  input  logic                          i_ex_ack,
  output logic [id_pkg::REG_ADDR_W-1:0] o_ex_rd,
  output logic                          o_ex_rd_wen,
  output id_pkg::itype_e                o_ex_itype,
  output logic [id_pkg::OPC_W-1:0]      o_ex_opcode,
  output logic [2:0]                    o_ex_funct3,
  output logic [6:0]                    o_ex_funct7,
  output logic [id_pkg::XLEN-1:0]       o_ex_op1,
  output logic [id_pkg::XLEN-1:0]       o_ex_op2,
  output logic [id_pkg::XLEN-1:0]       o_ex_t1,
  output logic                          o_ex_memren,
  output logic                          o_ex_memwen,
  output logic [id_pkg::XLEN-1:0]       o_ex_memaddr,
  output logic [id_pkg::XLEN-1:0]       o_ex_memwdata,
  output logic [id_pkg::XLEN-1:0]       o_ex_pc,
  output logic [id_pkg::XLEN-1:0]       o_ex_pc_pred,
  output logic                          o_ex_illegal
);

  fetch_if fch_bus ();
  dec_if   dec_bus ();

  logic [id_pkg::REG_ADDR_W-1:0] rs1;
  logic [id_pkg::REG_ADDR_W-1:0] rs2;
  logic [id_pkg::XLEN-1:0]       rs1_data;
  logic [id_pkg::XLEN-1:0]       rs2_data;

  id_stage u_stage (
    .clk         (clk),
    .rst         (rst),
    .i_fetch_req (i_fetch_req),
    .o_fetch_ack (o_fetch_ack),
    .i_inst      (i_inst),
    .i_pc        (i_pc),
    .i_pc_pred   (i_pc_pred),
    .fch         (fch_bus.stage),
    .i_pop       (dec_bus.pop)     // Freed when the output register loads
  );

  regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wb_en    (i_wb_en),
    .i_wb_rd    (i_wb_rd),
    .i_wb_data  (i_wb_data)
  );

  id_decoder u_decoder (
    .fch        (fch_bus.dec),
    .dec        (dec_bus.dec),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data)
  );

  id_ex_reg u_ex_reg (
    .clk           (clk),
    .rst           (rst),
    .dec           (dec_bus.ex),
    .o_ex_req      (o_ex_req),
    .i_ex_ack      (i_ex_ack),
    .o_ex_rd       (o_ex_rd),
    .o_ex_rd_wen   (o_ex_rd_wen),
    .o_ex_itype    (o_ex_itype),
    .o_ex_opcode   (o_ex_opcode),
    .o_ex_funct3   (o_ex_funct3),
    .o_ex_funct7   (o_ex_funct7),
    .o_ex_op1      (o_ex_op1),
    .o_ex_op2      (o_ex_op2),
    .o_ex_t1       (o_ex_t1),
    .o_ex_memren   (o_ex_memren),
    .o_ex_memwen   (o_ex_memwen),
    .o_ex_memaddr  (o_ex_memaddr),
    .o_ex_memwdata (o_ex_memwdata),
    .o_ex_pc       (o_ex_pc),
    .o_ex_pc_pred  (o_ex_pc_pred),
    .o_ex_illegal  (o_ex_illegal)
  );

endmodule

// File: tb/id_checker.sv
/* Execute side checker */

module id_checker (
  input logic                          clk,
  input logic                          rst,
  input logic                          i_req,
  input logic                          i_ack,
  input logic [id_pkg::REG_ADDR_W-1:0] i_rd,
  input logic                          i_rd_wen,
  input logic [2:0]                    i_itype,
  input logic [id_pkg::OPC_W-1:0]      i_opcode,
  input logic [2:0]                    i_funct3,
  input logic [6:0]                    i_funct7,
  input logic [id_pkg::XLEN-1:0]       i_op1,
  input logic [id_pkg::XLEN-1:0]       i_op2,
  input logic [id_pkg::XLEN-1:0]       i_t1,
  input logic                          i_memren,
  input logic                          i_memwen,
  input logic [id_pkg::XLEN-1:0]       i_memaddr,
  input logic [id_pkg::XLEN-1:0]       i_memwdata,
  input logic [id_pkg::XLEN-1:0]       i_pc,
  input logic [id_pkg::XLEN-1:0]       i_pc_pred,
  input logic                          i_illegal
);

  typedef struct {
    logic [63:0] rd, rd_wen, itype, opcode, funct3, funct7;
    logic [63:0] op1, op2, t1, memren, memwen, memaddr, memwdata;
    logic [63:0] pc, pc_pred, illegal;
  } exp_t;

  exp_t exp_q [$];
  int   err_count = 0;
  int   n_seen    = 0;
  logic pending   = 1'b0;
  logic after_rst = 1'b0;

  task automatic push_expected(
    input logic [4:0] rd, input logic rd_wen, input logic [2:0] itype,
    input logic [6:0] opcode, input logic [2:0] funct3, input logic [6:0] funct7,
    input logic [63:0] op1, input logic [63:0] op2, input logic [63:0] t1,
    input logic memren, input logic memwen, input logic [63:0] memaddr,
    input logic [63:0] memwdata, input logic [63:0] pc, input logic [63:0] pc_pred,
    input logic illegal);
    exp_t e;
    e = '{64'(rd), 64'(rd_wen), 64'(itype), 64'(opcode), 64'(funct3), 64'(funct7),
          op1, op2, t1, 64'(memren), 64'(memwen), memaddr, memwdata,
          pc, pc_pred, 64'(illegal)};
    exp_q.push_back(e);
  endtask

  task automatic check_field(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      $display("mismatch %s item %0d expected %h actual %h", name, n_seen, exp_v, act_v);
      err_count++;
    end
  endtask

  task automatic compare_transfer();
    exp_t e;
    if (exp_q.size() == 0) begin
      $display("execute transfer arrived with no expected bundle left");
      err_count++;
      return;
    end
    e = exp_q.pop_front();
    check_field("o_ex_rd", e.rd, 64'(i_rd));
    check_field("o_ex_rd_wen", e.rd_wen, 64'(i_rd_wen));
    check_field("o_ex_itype", e.itype, 64'(i_itype));
    check_field("o_ex_opcode", e.opcode, 64'(i_opcode));
    check_field("o_ex_funct3", e.funct3, 64'(i_funct3));
    check_field("o_ex_funct7", e.funct7, 64'(i_funct7));
    check_field("o_ex_op1", e.op1, i_op1);
    check_field("o_ex_op2", e.op2, i_op2);
    check_field("o_ex_t1", e.t1, i_t1);
    check_field("o_ex_memren", e.memren, 64'(i_memren));
    check_field("o_ex_memwen", e.memwen, 64'(i_memwen));
    check_field("o_ex_memaddr", e.memaddr, i_memaddr);
    check_field("o_ex_memwdata", e.memwdata, i_memwdata);
    check_field("o_ex_pc", e.pc, i_pc);
    check_field("o_ex_pc_pred", e.pc_pred, i_pc_pred);
    check_field("o_ex_illegal", e.illegal, 64'(i_illegal));
    n_seen++;
  endtask

  // Sampled mid cycle ahead of the rising edge that completes a transfer
  always @(negedge clk) begin
    if (rst) begin
      pending   = 1'b0;
      after_rst = 1'b1;
    end else begin
      if (after_rst && i_req !== 1'b0) begin
        $display("o_ex_req is not low right after reset");
        err_count++;
      end
      after_rst = 1'b0;
      if (pending && !i_req) begin
        $display("o_ex_req dropped before it was acknowledged");
        err_count++;
      end
      if (i_req && i_ack) compare_transfer();
      pending = i_req && !i_ack;
    end
  end

endmodule

// File: tb/tb_id_subsys.sv
/* Decode subsystem testbench */

module tb_id_subsys;

  localparam int NROWS   = 14;
  localparam int TIMEOUT = 200;

  typedef struct {
    logic [31:0] inst;
    logic [63:0] pc, pc_pred;
    logic [4:0]  rd;
    logic        rd_wen;
    logic [2:0]  itype;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [63:0] op1, op2, t1;
    logic        memren, memwen;
    logic [63:0] memaddr, memwdata;
    logic        illegal;
    logic        wb_en;     // Register write before this row
    logic [4:0]  wb_rd;
    logic [63:0] wb_data;
  } row_t;

  logic clk;
  logic rst;
  logic i_fetch_req, o_fetch_ack;
  logic [id_pkg::ILEN-1:0] i_inst;
  logic [id_pkg::XLEN-1:0] i_pc, i_pc_pred;
  logic i_wb_en;
  logic [id_pkg::REG_ADDR_W-1:0] i_wb_rd;
  logic [id_pkg::XLEN-1:0] i_wb_data;
  logic o_ex_req, i_ex_ack;
  logic [id_pkg::REG_ADDR_W-1:0] o_ex_rd;
  logic o_ex_rd_wen, o_ex_memren, o_ex_memwen, o_ex_illegal;
  id_pkg::itype_e o_ex_itype;
  logic [id_pkg::OPC_W-1:0] o_ex_opcode;
  logic [2:0] o_ex_funct3;
  logic [6:0] o_ex_funct7;
  logic [id_pkg::XLEN-1:0] o_ex_op1, o_ex_op2, o_ex_t1, o_ex_memaddr, o_ex_memwdata;
  logic [id_pkg::XLEN-1:0] o_ex_pc, o_ex_pc_pred;

  row_t        rows [NROWS];
  logic [63:0] shadow [32];
  int          timeouts = 0;

  id_subsys dut (.*);

  id_checker chk (
    .clk(clk), .rst(rst), .i_req(o_ex_req), .i_ack(i_ex_ack), .i_rd(o_ex_rd),
    .i_rd_wen(o_ex_rd_wen), .i_itype(o_ex_itype), .i_opcode(o_ex_opcode),
    .i_funct3(o_ex_funct3), .i_funct7(o_ex_funct7), .i_op1(o_ex_op1), .i_op2(o_ex_op2),
    .i_t1(o_ex_t1), .i_memren(o_ex_memren), .i_memwen(o_ex_memwen),
    .i_memaddr(o_ex_memaddr), .i_memwdata(o_ex_memwdata), .i_pc(o_ex_pc),
    .i_pc_pred(o_ex_pc_pred), .i_illegal(o_ex_illegal)
  );

  always #20 clk = ~clk;

  // Random back-pressure from execute
  always @(posedge clk) begin
    #2;
    if (rst) i_ex_ack = 1'b0;
    else     i_ex_ack = ($urandom() & 32'd1) != 32'd0;
  end

  task automatic write_reg(input int idx, input logic [63:0] data);
    i_wb_en   = 1'b1;
    i_wb_rd   = 5'(idx);
    i_wb_data = data;
    shadow[idx] = (idx == 0) ? '0 : data;  // x0 keeps zero
    @(posedge clk);
    #2;
    i_wb_en = 1'b0;
  endtask

  task automatic offer_fetch(input int r);
    logic done;
    done        = 1'b0;
    i_fetch_req = 1'b1;
    i_inst      = rows[r].inst;
    i_pc        = rows[r].pc;
    i_pc_pred   = rows[r].pc_pred;
    for (int t = 0; t < TIMEOUT && !done; t++) begin
      @(negedge clk);
      done = o_fetch_ack;
      @(posedge clk);
      #2;
    end
    i_fetch_req = 1'b0;
    if (!done) begin
      $display("timeout: fetch ack never came for row %0d", r);
      timeouts++;
    end
  endtask

  // ====================
  // Stimulus table
  // ====================
  // Register operands come from the shadow copy after preload
  task automatic fill_table();
    rows[0]  = '{32'h002081B3, 64'h100, 64'h104, 5'd3, 1'b1, id_pkg::IT_R, 3'd0, 7'h00,
                 shadow[1], shadow[2], 64'h0, 1'b0, 1'b0, 64'h0, 64'h0, 1'b0,
                 1'b0, 5'd0, 64'h0};
    rows[1]  = '{32'h40028033, 64'h104, 64'h108, 5'd0, 1'b0, id_pkg::IT_R, 3'd0, 7'h20,
                 shadow[5], shadow[0], 64'h0, 1'b0, 1'b0, 64'h0, 64'h0, 1'b0,
                 1'b0, 5'd0, 64'h0};
    rows[2]  = '{32'hFFB10213, 64'h108, 64'h10C, 5'd4, 1'b1, id_pkg::IT_I, 3'd0, 7'h7F,
                 shadow[2], 64'hFFFF_FFFF_FFFF_FFFB, 64'h0, 1'b0, 1'b0, 64'h0, 64'h0, 1'b0,
                 1'b0, 5'd0, 64'h0};
    rows[3]  = '{32'h4030D313, 64'h10C, 64'h110, 5'd6, 1'b1, id_pkg::IT_I, 3'd5, 7'h20,
                 shadow[1], 64'h403, 64'h0, 1'b0, 1'b0, 64'h0, 64'h0, 1'b0,
                 1'b0, 5'd0, 64'h0};
    rows[4]  = '{32'hFF053383, 64'h110, 64'h114, 5'd7, 1'b1, id_pkg::IT_I, 3'd3, 7'h00,
                 shadow[10], 64'hFFFF_FFFF_FFFF_FFF0, 64'h0, 1'b1, 1'b0,
                 shadow[10] - 64'h10, 64'h0, 1'b0, 1'b0, 5'd0, 64'h0};
    rows[5]  = '{32'h00313C23, 64'h114, 64'h118, 5'd0, 1'b0, id_pkg::IT_S, 3'd3, 7'h00,
                 shadow[2], 64'h18, 64'h0, 1'b0, 1'b1, shadow[2] + 64'h18, shadow[3], 1'b0,
                 1'b0, 5'd0, 64'h0};
    rows[6]  = '{32'hFE942E23, 64'h118, 64'h11C, 5'd0, 1'b0, id_pkg::IT_S, 3'd2, 7'h00,
                 shadow[8], 64'hFFFF_FFFF_FFFF_FFFC, 64'h0, 1'b0, 1'b1,
                 shadow[8] - 64'h4, shadow[9], 1'b0, 1'b0, 5'd0, 64'h0};
    rows[7]  = '{32'hFE208CE3, 64'h1000, 64'h1004, 5'd0, 1'b0, id_pkg::IT_B, 3'd0, 7'h00,
                 shadow[1], shadow[2], 64'hFF8, 1'b0, 1'b0, 64'h0, 64'h0, 1'b0,
                 1'b0, 5'd0, 64'h0};
    rows[8]  = '{32'h001000EF, 64'h2000, 64'h2800, 5'd1, 1'b1, id_pkg::IT_J, 3'd0, 7'h00,
                 64'h2000, 64'h4, 64'h2800, 1'b0, 1'b0, 64'h0, 64'h0, 1'b0, 1'b0, 5'd0, 64'h0};
    rows[9]  = '{32'h007182E7, 64'h3000, 64'h3004, 5'd5, 1'b1, id_pkg::IT_I, 3'd0, 7'h00,
                 64'h3000, 64'h4, (shadow[3] + 64'h7) & ~64'h1, 1'b0, 1'b0, 64'h0, 64'h0,
                 1'b0, 1'b0, 5'd0, 64'h0};
    rows[10] = '{32'h800005B7, 64'h3004, 64'h3008, 5'd11, 1'b1, id_pkg::IT_U, 3'd0, 7'h00,
                 64'h0, 64'hFFFF_FFFF_8000_0000, 64'h0, 1'b0, 1'b0, 64'h0, 64'h0, 1'b0,
                 1'b0, 5'd0, 64'h0};
    rows[11] = '{32'h12345617, 64'h4000, 64'h4004, 5'd12, 1'b1, id_pkg::IT_U, 3'd0, 7'h00,
                 64'h4000, 64'h1234_5000, 64'h0, 1'b0, 1'b0, 64'h0, 64'h0, 1'b0,
                 1'b0, 5'd0, 64'h0};
    rows[12] = '{32'h0000000B, 64'h4004, 64'h4008, 5'd0, 1'b0, id_pkg::IT_NONE, 3'd0, 7'h00,
                 64'h0, 64'h0, 64'h0, 1'b0, 1'b0, 64'h0, 64'h0, 1'b1, 1'b0, 5'd0, 64'h0};
    // x1 rewritten just before this fetch
    rows[13] = '{32'h002081B3, 64'h4008, 64'h400C, 5'd3, 1'b1, id_pkg::IT_R, 3'd0, 7'h00,
                 64'hDEAD_BEEF_0000_0001, shadow[2], 64'h0, 1'b0, 1'b0, 64'h0, 64'h0, 1'b0,
                 1'b1, 5'd1, 64'hDEAD_BEEF_0000_0001};
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    i_fetch_req = 1'b0;
    i_inst      = '0;
    i_pc        = '0;
    i_pc_pred   = '0;
    i_wb_en     = 1'b0;
    i_wb_rd     = '0;
    i_wb_data   = '0;
    i_ex_ack    = 1'b0;
    shadow[0]   = '0;
    void'($urandom(32'h872c_110a));
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;

    // Preload gives xN = N * 0x100, the write to x0 must be dropped
    write_reg(0, 64'hFFFF_0000_0000_0BAD);
    for (int i = 1; i < 32; i++) write_reg(i, 64'(i) * 64'h100);
    fill_table();

    for (int r = 0; r < NROWS; r++) begin
      if (rows[r].wb_en) write_reg(int'(rows[r].wb_rd), rows[r].wb_data);
      chk.push_expected(rows[r].rd, rows[r].rd_wen, rows[r].itype, rows[r].inst[6:0],
                        rows[r].funct3, rows[r].funct7, rows[r].op1, rows[r].op2,
                        rows[r].t1, rows[r].memren, rows[r].memwen, rows[r].memaddr,
                        rows[r].memwdata, rows[r].pc, rows[r].pc_pred, rows[r].illegal);
      offer_fetch(r);
    end

    // Drain the execute side
    for (int t = 0; t < TIMEOUT && chk.n_seen < NROWS; t++) @(negedge clk);
    if (chk.n_seen < NROWS) begin
      $display("timeout: only %0d of %0d bundles reached execute", chk.n_seen, NROWS);
      timeouts++;
    end
    repeat (4) @(posedge clk);

    $display("checker errors %0d, timeouts %0d", chk.err_count, timeouts);
    if (chk.err_count == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: id_subsys.f
verilog/id_pkg.sv
verilog/id_ifaces.sv
verilog/id_stage.sv
verilog/regfile.sv
verilog/id_decoder.sv
verilog/id_ex_reg.sv
verilog/id_subsys.sv
tb/id_checker.sv
tb/tb_id_subsys.sv

// File: run.sh
#!/bin/sh
# Build and run the decode subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing -f id_subsys.f --top-module tb_id_subsys -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "simulation did not complete"; exit 1; }

cat sim.log
grep -q "^PASS: all tests$" sim.log && exit 0 || exit 1
